// File: mem_pkg.sv
package mem_pkg;

    ////////////////////////////////////////
    // addresses and blocks
    ////////////////////////////////////////

    // byte address, only the line bits 15..3 are decoded
    typedef logic [31:0] addr_t;

    localparam int line_lsb = 3;
    localparam int line_msb = 15;

    // line address, byte address shifted down by the block size
    typedef logic [line_msb-line_lsb:0] line_t;

    // one memory block, one cache line
    typedef logic [63:0] block_t;

    ////////////////////////////////////////
    // memory transactions
    ////////////////////////////////////////

    localparam int mem_tag_bits = 4;
    localparam int mem_tags = 2 ** mem_tag_bits;

    // transaction tag, zero is the "no transaction" sentinel
    typedef logic [mem_tag_bits-1:0] mem_tag_t;
    localparam mem_tag_t mem_tag_none = '0;

    typedef enum logic [1:0] {
        mem_none = 2'd0,
        mem_load = 2'd1
    } mem_command_t;

    // line bits of a byte address
    function automatic line_t line_of(addr_t addr);
        return addr[line_msb:line_lsb];
    endfunction

    // block-aligned byte address of a line
    function automatic addr_t addr_of(line_t line);
        addr_t addr;
        addr = '0;
        addr[line_msb:line_lsb] = line;
        return addr;
    endfunction

endpackage

// File: icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////
    // tag array
    ////////////////////////////////////////

    // upper line bits above the index
    // full line width, so any line count fits without truncation
    typedef logic [$bits(mem_pkg::line_t)-1:0] cache_tag_t;

    // one entry per cache line
    typedef struct packed {
        cache_tag_t tag;
        // block present in storage
        logic valid;
        // load issued, block not back yet
        logic allocated;
    } tag_entry_t;

    ////////////////////////////////////////
    // prefetcher
    ////////////////////////////////////////

    // idle only right after reset
    // window_done parks the walk until the fetch line moves
    typedef enum logic [1:0] {
        idle        = 2'd0,
        issue       = 2'd1,
        window_done = 2'd2
    } prefetch_state_t;

endpackage

// File: icache_mem.sv
`timescale 1ns/1ps

module icache_mem #(
    parameter int lines = 32,
    localparam int index_bits = $clog2(lines)
) (
    input  logic                           clock,
    input  logic                           reset,
    // two read ports, line L and line L+1
    input  logic [1:0][index_bits-1:0]     raddr,
    output mem_pkg::block_t [1:0]          rdata,
    // single write port from the prefetcher
    input  logic                           write_en,
    input  logic [index_bits-1:0]          waddr,
    input  mem_pkg::block_t                wdata
);
    import mem_pkg::*;

    // block storage, no reset, the tag array guards it
    block_t mem_array [lines];

    ////////////////////////////////////////
    // write port
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (write_en) begin
            mem_array[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////
    // read ports with bypass
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // block being written shows up in the same cycle
            if (write_en && (waddr == raddr[i])) begin
                rdata[i] = wdata;
            end else begin
                rdata[i] = mem_array[raddr[i]];
            end
        end
    end

    // a write with an unknown index would corrupt an arbitrary line
    write_index_known: assert property (
        @(posedge clock) disable iff (reset)
        write_en |-> !$isunknown(waddr)
    ) else $error("icache_mem: write with unknown index");

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int lines = 32,
    localparam int index_bits = $clog2(lines)
) (
    input  logic                   clock,
    input  logic                   reset,
    // fetch side, combinational lookup
    input  mem_pkg::addr_t         fetch_addr,
    output mem_pkg::block_t [1:0]  fetch_data,
    output logic [1:0]             fetch_valid,
    // probe from the prefetcher
    input  mem_pkg::addr_t         probe_addr,
    output logic                   probe_present,
    // request accepted by memory
    input  logic                   alloc_en,
    input  mem_pkg::addr_t         alloc_addr,
    // block returned by memory
    input  logic                   write_en,
    input  mem_pkg::addr_t         write_addr,
    input  mem_pkg::block_t        write_data
);
    import mem_pkg::*;
    import icache_pkg::*;

    tag_entry_t                  tags [lines];

    line_t [1:0]                 fetch_line;
    logic  [1:0][index_bits-1:0] fetch_index;
    cache_tag_t [1:0]            fetch_tag;

    logic [index_bits-1:0]       write_index;
    cache_tag_t                  write_tag;
    logic [index_bits-1:0]       alloc_index;
    cache_tag_t                  alloc_tag;
    logic [index_bits-1:0]       probe_index;
    cache_tag_t                  probe_tag;

    function automatic cache_tag_t tag_of(line_t line);
        return cache_tag_t'(line >> index_bits);
    endfunction

    ////////////////////////////////////////
    // address split
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // L+1 wraps the index and carries into the tag
            fetch_line[i]  = line_of(fetch_addr) + line_t'(i);
            fetch_index[i] = fetch_line[i][index_bits-1:0];
            fetch_tag[i]   = tag_of(fetch_line[i]);
        end
    end

    assign write_index = write_addr[line_lsb +: index_bits];
    assign write_tag   = tag_of(line_of(write_addr));
    assign alloc_index = alloc_addr[line_lsb +: index_bits];
    assign alloc_tag   = tag_of(line_of(alloc_addr));
    assign probe_index = probe_addr[line_lsb +: index_bits];
    assign probe_tag   = tag_of(line_of(probe_addr));

    ////////////////////////////////////////
    // lookups
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            // a write in flight decides the hit, matching the data bypass
            if (write_en && (write_index == fetch_index[i])) begin
                fetch_valid[i] = (write_tag == fetch_tag[i]);
            end else begin
                fetch_valid[i] = tags[fetch_index[i]].valid &&
                                 (tags[fetch_index[i]].tag == fetch_tag[i]);
            end
        end
    end

    // resident or already requested
    assign probe_present = (tags[probe_index].valid || tags[probe_index].allocated) &&
                           (tags[probe_index].tag == probe_tag);

    ////////////////////////////////////////
    // tag array update
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < lines; i++) begin
                tags[i] <= '0;
            end
        end else begin
            if (alloc_en) begin
                tags[alloc_index] <= '{tag: alloc_tag, valid: 1'b0, allocated: 1'b1};
            end
            if (write_en) begin
                tags[write_index] <= '{tag: write_tag, valid: 1'b1, allocated: 1'b0};
            end
        end
    end

    icache_mem #(
        .lines(lines)
    ) blocks (
        .clock   (clock),
        .reset   (reset),
        .raddr   (fetch_index),
        .rdata   (fetch_data),
        .write_en(write_en),
        .waddr   (write_index),
        .wdata   (write_data)
    );

    // the prefetcher holds off requests that would alias a returning block
    no_alloc_write_clash: assert property (
        @(posedge clock) disable iff (reset)
        (alloc_en && write_en) |-> (alloc_index != write_index)
    ) else $error("icache: allocation and write hit the same line");

endmodule

// File: icache_prefetcher.sv
`timescale 1ns/1ps

module icache_prefetcher #(
    parameter int prefetch_distance = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  mem_pkg::addr_t        fetch_addr,
    // cache probe
    output mem_pkg::addr_t        probe_addr,
    input  logic                  probe_present,
    // tag array updates
    output logic                  alloc_en,
    output mem_pkg::addr_t        alloc_addr,
    output logic                  write_en,
    output mem_pkg::addr_t        write_addr,
    output mem_pkg::block_t       write_data,
    // memory port
    output mem_pkg::mem_command_t mem_command,
    output mem_pkg::addr_t        mem_addr,
    input  mem_pkg::mem_tag_t     mem_response_tag,
    input  mem_pkg::block_t       mem_data,
    input  mem_pkg::mem_tag_t     mem_data_tag
);
    import mem_pkg::*;
    import icache_pkg::*;

    localparam line_t distance = line_t'(prefetch_distance);

    prefetch_state_t state;
    prefetch_state_t next_state;
    // walk pointer, a line address
    line_t           ptr;
    line_t           next_ptr;

    // outstanding transactions, indexed by memory tag, entry 0 unused
    logic [mem_tags-1:1] busy;
    line_t               table_line [mem_tags-1:1];

    line_t fetch_line;
    line_t ptr_offset;
    line_t cur_line;
    line_t write_line;
    logic  in_window;
    logic  pending;
    logic  data_hit;
    logic  hold;
    logic  missing;
    logic  accepted;

    ////////////////////////////////////////
    // window and current line
    ////////////////////////////////////////

    assign fetch_line = line_of(fetch_addr);
    assign ptr_offset = ptr - fetch_line;
    assign in_window  = (ptr_offset < distance);

    // pointer left the window, restart at L
    assign cur_line = in_window ? ptr : fetch_line;

    // already in flight, even if its cache entry was taken over since
    always_comb begin
        pending = 1'b0;
        for (int t = 1; t < mem_tags; t++) begin
            if (busy[t] && (table_line[t] == cur_line)) begin
                pending = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // returning data
    ////////////////////////////////////////

    always_comb begin
        data_hit   = 1'b0;
        write_line = '0;
        if (mem_data_tag != mem_tag_none) begin
            data_hit   = busy[mem_data_tag];
            write_line = table_line[mem_data_tag];
        end
    end

    assign write_en   = data_hit;
    assign write_addr = addr_of(write_line);
    assign write_data = mem_data;

    // stale block from an old window may alias the line we would allocate
    assign hold = data_hit && ((write_line - fetch_line) >= distance);

    ////////////////////////////////////////
    // request
    ////////////////////////////////////////

    assign missing     = !probe_present && !pending;
    assign probe_addr  = addr_of(cur_line);
    assign mem_addr    = addr_of(cur_line);
    assign mem_command = ((state == issue) && missing && !hold) ? mem_load : mem_none;
    assign accepted    = (mem_command == mem_load) && (mem_response_tag != mem_tag_none);
    assign alloc_en    = accepted;
    assign alloc_addr  = addr_of(cur_line);

    ////////////////////////////////////////
    // walk FSM
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        next_ptr   = ptr;
        case (state)
            idle: begin
                next_state = issue;
                next_ptr   = fetch_line;
            end
            issue: begin
                // refused, same line again next cycle
                next_ptr = cur_line;
                if (!missing || accepted) begin
                    next_ptr = cur_line + line_t'(1);
                    if ((cur_line - fetch_line) == distance - line_t'(1)) begin
                        next_state = window_done;
                    end
                end
            end
            window_done: begin
                // fetch line moved, issue reloads on a jump
                if (ptr_offset != distance) begin
                    next_state = issue;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
        // stale block may have evicted a window line, walk again from L
        if (hold) begin
            next_state = issue;
            next_ptr   = fetch_line;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
            ptr   <= '0;
            busy  <= '0;
        end else begin
            state <= next_state;
            ptr   <= next_ptr;
            // free before claim, memory may reuse a tag in its return cycle
            if (data_hit) begin
                busy[mem_data_tag] <= 1'b0;
            end
            if (accepted) begin
                busy[mem_response_tag] <= 1'b1;
            end
        end
    end

    // line address per transaction
    always_ff @(posedge clock) begin
        if (accepted) begin
            table_line[mem_response_tag] <= cur_line;
        end
    end

    data_tag_in_use: assert property (
        @(posedge clock) disable iff (reset)
        (mem_data_tag != mem_tag_none) |-> busy[mem_data_tag]
    ) else $error("icache_prefetcher: data returned for a free tag");

    response_tag_free: assert property (
        @(posedge clock) disable iff (reset)
        (mem_response_tag != mem_tag_none) |->
            (!busy[mem_response_tag] || (mem_data_tag == mem_response_tag))
    ) else $error("icache_prefetcher: memory handed out a tag in use");

endmodule

// File: icache_subsystem.sv
`timescale 1ns/1ps

module icache_subsystem #(
    parameter int lines = 32,
    parameter int prefetch_distance = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    // fetch unit
    input  mem_pkg::addr_t        fetch_addr,
    output mem_pkg::block_t [1:0] fetch_data,
    output logic [1:0]            fetch_valid,
    // memory
    output mem_pkg::mem_command_t mem_command,
    output mem_pkg::addr_t        mem_addr,
    input  mem_pkg::mem_tag_t     mem_response_tag,
    input  mem_pkg::block_t       mem_data,
    input  mem_pkg::mem_tag_t     mem_data_tag
);
    import mem_pkg::*;

    // prefetcher to cache
    addr_t  probe_addr;
    logic   probe_present;
    logic   alloc_en;
    addr_t  alloc_addr;
    logic   write_en;
    addr_t  write_addr;
    block_t write_data;

    icache #(
        .lines(lines)
    ) cache (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .fetch_valid  (fetch_valid),
        .probe_addr   (probe_addr),
        .probe_present(probe_present),
        .alloc_en     (alloc_en),
        .alloc_addr   (alloc_addr),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .write_data   (write_data)
    );

    icache_prefetcher #(
        .prefetch_distance(prefetch_distance)
    ) prefetcher (
        .clock           (clock),
        .reset           (reset),
        .fetch_addr      (fetch_addr),
        .probe_addr      (probe_addr),
        .probe_present   (probe_present),
        .alloc_en        (alloc_en),
        .alloc_addr      (alloc_addr),
        .write_en        (write_en),
        .write_addr      (write_addr),
        .write_data      (write_data),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_response_tag(mem_response_tag),
        .mem_data        (mem_data),
        .mem_data_tag    (mem_data_tag)
    );

endmodule

// File: tb_memory_model.sv
`timescale 1ns/1ps

module tb_memory_model #(
    parameter int lines = 32,
    parameter int latency = 6
) (
    input  logic                  clock,
    input  logic                  reset,
    input  mem_pkg::mem_command_t mem_command,
    input  mem_pkg::addr_t        mem_addr,
    output mem_pkg::mem_tag_t     mem_response_tag,
    output mem_pkg::block_t       mem_data,
    output mem_pkg::mem_tag_t     mem_data_tag,
    output int                    duplicates
);
    import mem_pkg::*;

    localparam int index_bits = $clog2(lines);

    logic [31:0]      lfsr;
    // refusal decision for the current cycle
    logic             refuse;
    logic [15:1]      in_use;
    addr_t            tag_addr [1:15];
    int               due [1:15];
    int               cycle;
    // shadow of the line each cache index holds
    logic [12:0]      resident_line [lines];
    logic [lines-1:0] resident_valid;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end
        return state >> 1;
    endfunction

    // quiet return bus until the first clock edge
    initial begin
        mem_data     = '0;
        mem_data_tag = mem_tag_none;
    end

    // lowest free tag, zero on refusal or when all tags are out
    always_comb begin
        mem_response_tag = mem_tag_none;
        if (!reset && (mem_command == mem_load) && !refuse) begin
            for (int t = 15; t >= 1; t--) begin
                if (!in_use[t]) begin
                    mem_response_tag = mem_tag_t'(t);
                end
            end
        end
    end

    always @(posedge clock) begin : update
        logic [31:0]           first;
        logic [31:0]           second;
        logic [12:0]           line;
        logic [index_bits-1:0] index;
        logic                  repeated;
        if (reset) begin
            lfsr           <= 32'h71277661;
            refuse         <= 1'b0;
            in_use         <= '0;
            cycle          <= 0;
            duplicates     <= 0;
            mem_data       <= '0;
            mem_data_tag   <= mem_tag_none;
            resident_valid <= '0;
        end else begin
            // two bits per cycle, refuse when both are set
            first  = next_lfsr(lfsr);
            second = next_lfsr(first);
            lfsr   <= second;
            refuse <= first[0] & second[0];
            cycle  <= cycle + 1;
            if ((mem_command == mem_load) && (mem_response_tag != mem_tag_none)) begin
                line     = mem_addr[15:3];
                index    = line[index_bits-1:0];
                repeated = resident_valid[index] && (resident_line[index] == line);
                for (int t = 1; t < 16; t++) begin
                    if (in_use[t] && (tag_addr[t][15:3] == line)) begin
                        repeated = 1'b1;
                    end
                end
                if (repeated) begin
                    $display("memory model: duplicate request for line %h at %0t ns",
                             line, $time);
                    duplicates <= duplicates + 1;
                end
                in_use[mem_response_tag]   <= 1'b1;
                tag_addr[mem_response_tag] <= mem_addr;
                due[mem_response_tag]      <= cycle + latency;
                // allocation takes the index over
                resident_valid[index]      <= 1'b0;
            end
            // block on the bus this cycle lands in the cache
            if (mem_data_tag != mem_tag_none) begin
                line  = tag_addr[mem_data_tag][15:3];
                index = line[index_bits-1:0];
                in_use[mem_data_tag]  <= 1'b0;
                resident_line[index]  <= line;
                resident_valid[index] <= 1'b1;
            end
            mem_data_tag <= mem_tag_none;
            for (int t = 1; t < 16; t++) begin
                if (in_use[t] && (due[t] == cycle + 1)) begin
                    mem_data_tag <= mem_tag_t'(t);
                    mem_data     <= {tag_addr[t], ~tag_addr[t]};
                end
            end
        end
    end

endmodule

// File: tb_icache_subsystem.sv
`timescale 1ns/1ps

module tb_icache_subsystem;
    import mem_pkg::*;

    localparam int lines = 32;
    localparam int prefetch_distance = 4;
    localparam int period = 20;
    localparam int reset_cycles = 3;
    localparam int margin_cycles = 100;

    typedef struct packed {
        logic [31:0] addr;
        int          hold;
        // neither line may hit in the first cycle
        logic        cold;
        // both lines must hit at the end of the hold
        logic        full;
    } step_t;

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    localparam int num_steps = 14;
    localparam step_t steps [num_steps] = '{
        '{32'h0000_0000, 30, 1'b1, 1'b1},
        '{32'h0000_0008,  4, 1'b0, 1'b0},
        '{32'h0000_0010,  3, 1'b0, 1'b0},
        '{32'h0000_0018, 25, 1'b0, 1'b1},
        // same index as line 0, other tag
        '{32'h0000_0100, 30, 1'b1, 1'b1},
        '{32'h0000_0000, 30, 1'b1, 1'b1},
        // L+1 wraps the index
        '{32'h0000_00f8, 30, 1'b1, 1'b1},
        // L+1 wraps the line address
        '{32'h0000_fff8, 30, 1'b1, 1'b1},
        // jumps while loads are in flight
        '{32'h0000_4000,  2, 1'b1, 1'b0},
        '{32'h0000_8000,  2, 1'b1, 1'b0},
        '{32'h0000_4000, 30, 1'b0, 1'b1},
        '{32'h0000_0020,  1, 1'b0, 1'b0},
        '{32'h0000_0028, 20, 1'b0, 1'b1},
        '{32'h0000_0130, 40, 1'b1, 1'b1}
    };

    logic            clock = 1'b0;
    logic            reset;
    addr_t           fetch_addr;
    block_t [1:0]    fetch_data;
    logic [1:0]      fetch_valid;
    mem_command_t    mem_command;
    addr_t           mem_addr;
    mem_tag_t        mem_response_tag;
    block_t          mem_data;
    mem_tag_t        mem_data_tag;
    int              duplicates;

    int              errors = 0;
    int              checks = 0;
    logic            checking = 1'b0;
    // refusal seen last cycle, retry expected now
    logic            retry_due = 1'b0;
    addr_t           refused_addr;
    addr_t           refused_fetch;

    always #(period / 2) clock = ~clock;

    icache_subsystem #(
        .lines            (lines),
        .prefetch_distance(prefetch_distance)
    ) UUT (
        .clock           (clock),
        .reset           (reset),
        .fetch_addr      (fetch_addr),
        .fetch_data      (fetch_data),
        .fetch_valid     (fetch_valid),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_response_tag(mem_response_tag),
        .mem_data        (mem_data),
        .mem_data_tag    (mem_data_tag)
    );

    tb_memory_model #(
        .lines  (lines),
        .latency(6)
    ) memory (
        .clock           (clock),
        .reset           (reset),
        .mem_command     (mem_command),
        .mem_addr        (mem_addr),
        .mem_response_tag(mem_response_tag),
        .mem_data        (mem_data),
        .mem_data_tag    (mem_data_tag),
        .duplicates      (duplicates)
    );

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // address of the line in the upper half, its inverse below
    function automatic block_t line_content(addr_t addr, int offset);
        logic [12:0] line;
        addr_t       base;
        line = addr[15:3] + 13'(offset);
        base = {16'h0000, line, 3'b000};
        return {base, ~base};
    endfunction

    ////////////////////////////////////////
    // per-cycle checks, mid-cycle
    ////////////////////////////////////////

    always @(negedge clock) begin
        logic [12:0] offset;
        if (checking) begin
            for (int i = 0; i < 2; i++) begin
                if (fetch_valid[i] === 1'b1) begin
                    compare($sformatf("fetch_data[%0d]", i), fetch_data[i],
                            line_content(fetch_addr, i));
                end
            end
            // a jump or a returning block may move the walk
            if (retry_due && (fetch_addr == refused_fetch) && (mem_data_tag == mem_tag_none)) begin
                compare("mem_command on retry", mem_command, mem_load);
                compare("mem_addr on retry", mem_addr, refused_addr);
            end
            retry_due = 1'b0;
            if (mem_command == mem_load) begin
                offset = mem_addr[15:3] - fetch_addr[15:3];
                compare("mem_addr inside window", offset < prefetch_distance, 1);
                if (mem_response_tag == mem_tag_none) begin
                    retry_due     = 1'b1;
                    refused_addr  = mem_addr;
                    refused_fetch = fetch_addr;
                end
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        int errors_before;
        reset      = 1'b1;
        fetch_addr = '0;
        repeat (reset_cycles) @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        compare("fetch_valid after reset", fetch_valid, 0);
        compare("mem_command after reset", mem_command, mem_none);
        $display("test 0: reset, %0d errors", errors);
        checking = 1'b1;
        for (int n = 0; n < num_steps; n++) begin
            errors_before = errors;
            @(posedge clock);
            #1 fetch_addr = steps[n].addr;
            @(negedge clock);
            if (steps[n].cold) begin
                compare("fetch_valid on a new line", fetch_valid, 2'b00);
            end
            repeat (steps[n].hold - 1) @(negedge clock);
            if (steps[n].full) begin
                compare("fetch_valid after hold", fetch_valid, 2'b11);
            end
            $display("test %0d: fetch_addr %h held %0d cycles, %0d errors",
                     n + 1, steps[n].addr, steps[n].hold, errors - errors_before);
        end
        checking = 1'b0;
        $display("%0d tests, %0d checks, %0d errors, %0d duplicate requests",
                 num_steps + 1, checks, errors, duplicates);
        if ((errors == 0) && (duplicates == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // limit from the table, one extra cycle per step plus margin
    initial begin : watchdog
        int limit;
        limit = reset_cycles + margin_cycles;
        for (int n = 0; n < num_steps; n++) begin
            limit += steps[n].hold + 1;
        end
        #(limit * period);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
mem_pkg.sv
icache_pkg.sv
icache_mem.sv
icache.sv
icache_prefetcher.sv
icache_subsystem.sv
tb_memory_model.sv
tb_icache_subsystem.sv

// File: Makefile
TOP = tb_icache_subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
